//--- verilog/cp_pkg.sv
/* types and default sizes shared by the cyclic prefix inserter
   LATENCY_RD is fixed by the memory read register plus the reader output register */
package cp_pkg;

  // one complex sample, imaginary in the upper half
  typedef struct packed {
    logic [15:0] im;               // imaginary part
    logic [15:0] re;               // real part
  } sample_t;

  // block timestamp carried from input sop to output
  typedef struct packed {
    logic [9:0] frame;             // frame number
    logic [7:0] slot;              // slot in frame
    logic [3:0] symbol;            // symbol in slot
  } stamp_t;

  localparam int FFT_SIZE_DEF     = 64;   // samples per symbol
  localparam int CP_LEN_LONG_DEF  = 16;   // long prefix
  localparam int CP_LEN_SHORT_DEF = 8;    // short prefix
  localparam int BLOCK_QTY_DEF    = 4;    // ring depth in blocks
  localparam int LATENCY_RD       = 2;    // read addr to output data

endpackage

//--- verilog/block_ram.sv
/* simple dual-port memory, one cycle registered read, no reset on contents
   a read of the address being written returns the old word */
`timescale 1ns/100ps

module block_ram #(
  parameter int  DEPTH  = 64,
  parameter type word_t = logic [31:0],
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input  logic              clk_rd,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  word_t             wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output word_t             rd_data
);

  word_t mem [DEPTH];                        // storage array

  always_ff @(posedge clk_rd) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;               // write port
    end
    rd_data <= mem[rd_addr];                 // registered read
  end

endmodule

//--- verilog/block_ring.sv
/* block pointers and occupancy for the sample ring, needs BLOCK_QTY >= 2
   commit when full or release when empty is not guarded here */
`timescale 1ns/100ps

module block_ring #(
  parameter int  BLOCK_QTY = cp_pkg::BLOCK_QTY_DEF,
  localparam int BLK_W     = $clog2(BLOCK_QTY),
  localparam int USED_W    = $clog2(BLOCK_QTY + 1)
) (
  input  logic              clk_rd,
  input  logic              rst_n,
  input  logic              commit,          // block written
  input  logic              rd_release,      // block consumed
  output logic [BLK_W-1:0]  wr_block,
  output logic [BLK_W-1:0]  rd_block,
  output logic [USED_W-1:0] bloc_used,
  output logic              full,
  output logic              empty
);

  assign full  = bloc_used == USED_W'(BLOCK_QTY);
  assign empty = bloc_used == '0;

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      wr_block <= '0;
      rd_block <= '0;
    end else begin
      if (commit) begin
        wr_block <= (wr_block == BLK_W'(BLOCK_QTY - 1)) ? '0 : wr_block + 1'b1;  // wrap
      end
      if (rd_release) begin
        rd_block <= (rd_block == BLK_W'(BLOCK_QTY - 1)) ? '0 : rd_block + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      bloc_used <= '0;
    end else begin
      case ({commit, rd_release})
        2'b10:   bloc_used <= bloc_used + 1'b1;
        2'b01:   bloc_used <= bloc_used - 1'b1;
        default: bloc_used <= bloc_used;     // none, or both cancel
      endcase
    end
  end

endmodule

//--- verilog/block_writer.sv
/* write side, samples go to wr_block*FFT_SIZE+offset in the cycle they arrive
   a packet starting while full, or cut by din_restart, is dropped until the next sop */
`timescale 1ns/100ps

module block_writer #(
  parameter int  FFT_SIZE  = cp_pkg::FFT_SIZE_DEF,
  parameter int  BLOCK_QTY = cp_pkg::BLOCK_QTY_DEF,
  localparam int BLK_W     = $clog2(BLOCK_QTY),
  localparam int OFFS_W    = $clog2(FFT_SIZE),
  localparam int ADDR_W    = $clog2(FFT_SIZE * BLOCK_QTY)
) (
  input  logic              clk_rd,
  input  logic              rst_n,
  input  logic              din_valid,
  input  logic              din_sop,
  input  logic              din_eop,
  input  logic              din_restart,
  input  cp_pkg::stamp_t    din_stamp,
  input  logic              full,
  input  logic [BLK_W-1:0]  wr_block,
  output logic              wr_en,
  output logic [ADDR_W-1:0] wr_addr,
  output logic              stamp_en,
  output cp_pkg::stamp_t    wr_stamp,
  output logic              commit,
  output logic [31:0]       overflow_cnt
);

  logic [OFFS_W-1:0] offset_q;               // next sample offset
  logic              discard_q;              // packet being dropped
  logic [OFFS_W-1:0] offset;
  logic              start;
  logic              drop;

  assign start    = din_valid & din_sop;
  assign offset   = start ? '0 : offset_q;   // sop restarts the block
  assign drop     = din_restart | (start ? full : discard_q);
  assign wr_en    = din_valid & ~drop;
  assign wr_addr  = ADDR_W'(wr_block) * ADDR_W'(FFT_SIZE) + ADDR_W'(offset);
  assign stamp_en = wr_en & start;           // stamp taken with sop
  assign wr_stamp = din_stamp;
  assign commit   = wr_en & (offset == OFFS_W'(FFT_SIZE - 1));  // last sample

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      offset_q  <= '0;
      discard_q <= 1'b1;                     // ignore beats until first sop
    end else begin
      if (din_restart | commit) begin
        discard_q <= 1'b1;                   // extra beats after commit dropped too
      end else if (start) begin
        discard_q <= full;
      end
      if (wr_en) begin
        offset_q <= offset + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      overflow_cnt <= '0;
    end else if (din_valid & din_eop & drop) begin
      overflow_cnt <= overflow_cnt + 1'b1;   // one count per dropped packet
    end
  end

endmodule

//--- verilog/cp_reader.sv
/* read side, one symbol per trigger edge, prefix then whole block
   assumes CP_LEN_LONG >= CP_LEN_SHORT, triggers ignored until the symbol has left */
`timescale 1ns/100ps

module cp_reader #(
  parameter int  FFT_SIZE     = cp_pkg::FFT_SIZE_DEF,
  parameter int  CP_LEN_LONG  = cp_pkg::CP_LEN_LONG_DEF,
  parameter int  CP_LEN_SHORT = cp_pkg::CP_LEN_SHORT_DEF,
  parameter int  BLOCK_QTY    = cp_pkg::BLOCK_QTY_DEF,
  localparam int BLK_W        = $clog2(BLOCK_QTY),
  localparam int ADDR_W       = $clog2(FFT_SIZE * BLOCK_QTY),
  localparam int IDX_W        = $clog2(FFT_SIZE + CP_LEN_LONG),
  localparam int LAT          = cp_pkg::LATENCY_RD
) (
  input  logic              clk_rd,
  input  logic              rst_n,
  input  logic              dout_trigger,
  input  logic              long_cp,
  input  logic              dout_repeat,
  input  logic              dout_ready,
  input  logic [1:0]        dout_enable,     // bit 0 real, bit 1 imag
  input  logic              empty,
  input  logic [BLK_W-1:0]  rd_block,
  input  cp_pkg::sample_t   rd_data,
  output logic [ADDR_W-1:0] rd_addr,
  output logic              rd_release,
  output logic              dout_sop,
  output logic              dout_eop,
  output logic              dout_valid,
  output logic              dmem_valid,
  output logic [15:0]       dout_real,
  output logic [15:0]       dout_imag,
  output logic [IDX_W-1:0]  dout_index
);

  logic             trig_q;                  // trigger last cycle
  logic             active;                  // address phase running
  logic [IDX_W-1:0] index;                   // position in symbol
  logic             long_q;
  logic             repeat_q;                // hold block after symbol
  logic             den_q;                   // stored data emitted
  logic [IDX_W-1:0] cp_len;
  logic [IDX_W-1:0] offset;
  logic             busy;
  logic             start;
  logic             last;
  logic [LAT:1]     valid_d;                 // framing delay line
  logic [LAT:1]     sop_d;
  logic [LAT:1]     eop_d;
  logic [LAT:1]     den_d;
  cp_pkg::sample_t  data_q;                  // output data register

  assign busy   = active | (|valid_d);       // until dout_eop has gone out
  assign start  = dout_trigger & ~trig_q & ~busy;
  assign cp_len = long_q ? IDX_W'(CP_LEN_LONG) : IDX_W'(CP_LEN_SHORT);
  assign last   = index == cp_len + IDX_W'(FFT_SIZE - 1);

  // prefix reads the block tail, then the block from offset 0
  assign offset  = (index < cp_len) ? IDX_W'(FFT_SIZE) - cp_len + index : index - cp_len;
  assign rd_addr = ADDR_W'(rd_block) * ADDR_W'(FFT_SIZE) + ADDR_W'(offset);

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      trig_q <= 1'b1;                        // level high at reset is no edge
    end else begin
      trig_q <= dout_trigger;
    end
  end

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      index    <= '0;
      long_q   <= 1'b0;
      repeat_q <= 1'b0;
      den_q    <= 1'b0;
    end else if (start) begin
      active   <= 1'b1;
      index    <= '0;
      long_q   <= long_cp;                   // prefix length fixed per symbol
      repeat_q <= dout_repeat;
      den_q    <= ~empty & dout_ready;
    end else if (active) begin
      active <= ~last;
      index  <= last ? '0 : index + 1'b1;
    end
  end

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      valid_d <= '0;
      sop_d   <= '0;
      eop_d   <= '0;
      den_d   <= '0;
    end else begin
      valid_d <= {valid_d[LAT-1:1], active};
      sop_d   <= {sop_d[LAT-1:1], active & (index == '0)};
      eop_d   <= {eop_d[LAT-1:1], active & last};
      den_d   <= {den_d[LAT-1:1], active & den_q};
    end
  end

  always_ff @(posedge clk_rd) begin
    data_q <= rd_data;                       // second read stage
  end

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      dout_index <= '0;
    end else if (dout_valid) begin
      dout_index <= dout_eop ? '0 : dout_index + 1'b1;
    end
  end

  assign dout_valid = valid_d[LAT];
  assign dout_sop   = sop_d[LAT];
  assign dout_eop   = eop_d[LAT];
  assign dmem_valid = valid_d[LAT] & den_d[LAT];
  assign dout_real  = (dmem_valid & dout_enable[0]) ? data_q.re : '0;
  assign dout_imag  = (dmem_valid & dout_enable[1]) ? data_q.im : '0;
  assign rd_release = eop_d[LAT] & den_d[LAT] & ~repeat_q;  // frees block after eop

endmodule

//--- verilog/cp_insertion.sv
/* cyclic prefix insertion on one clock, BLOCK_QTY >= 2 and CP_LEN_LONG >= CP_LEN_SHORT
   no input back-pressure, overflowing packets are dropped whole and counted */
`timescale 1ns/100ps

module cp_insertion #(
  parameter int  FFT_SIZE     = cp_pkg::FFT_SIZE_DEF,
  parameter int  CP_LEN_LONG  = cp_pkg::CP_LEN_LONG_DEF,
  parameter int  CP_LEN_SHORT = cp_pkg::CP_LEN_SHORT_DEF,
  parameter int  BLOCK_QTY    = cp_pkg::BLOCK_QTY_DEF,
  localparam int BLK_W        = $clog2(BLOCK_QTY),
  localparam int USED_W       = $clog2(BLOCK_QTY + 1),
  localparam int ADDR_W       = $clog2(FFT_SIZE * BLOCK_QTY),
  localparam int IDX_W        = $clog2(FFT_SIZE + CP_LEN_LONG)
) (
  input  logic              clk_rd,
  input  logic              rst_n,
  input  logic              din_valid,
  input  logic              din_sop,
  input  logic              din_eop,
  input  logic              din_restart,     // drop packet in progress
  input  cp_pkg::sample_t   din_data,
  input  cp_pkg::stamp_t    din_stamp,       // taken with sop
  input  logic              dout_trigger,
  input  logic              long_cp,
  input  logic              dout_repeat,
  input  logic              dout_ready,
  input  logic [1:0]        dout_enable,
  output logic              dout_sop,
  output logic              dout_eop,
  output logic              dout_valid,
  output logic              dmem_valid,
  output logic [15:0]       dout_real,
  output logic [15:0]       dout_imag,
  output cp_pkg::stamp_t    dout_stamp,
  output logic [IDX_W-1:0]  dout_index,
  output logic [USED_W-1:0] bloc_used,
  output logic              bloc_full,
  output logic              bloc_empty,
  output logic [31:0]       overflow_cnt
);

  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic              stamp_en;
  cp_pkg::stamp_t    wr_stamp;
  logic              commit;
  logic              rd_release;
  logic [BLK_W-1:0]  wr_block;
  logic [BLK_W-1:0]  rd_block;
  logic [ADDR_W-1:0] rd_addr;
  cp_pkg::sample_t   rd_data;

  block_writer #(.FFT_SIZE(FFT_SIZE), .BLOCK_QTY(BLOCK_QTY)) i_block_writer (
    .clk_rd, .rst_n, .din_valid, .din_sop, .din_eop, .din_restart, .din_stamp,
    .full(bloc_full), .wr_block, .wr_en, .wr_addr, .stamp_en, .wr_stamp,
    .commit, .overflow_cnt
  );

  block_ring #(.BLOCK_QTY(BLOCK_QTY)) i_block_ring (
    .clk_rd, .rst_n, .commit, .rd_release, .wr_block, .rd_block, .bloc_used,
    .full(bloc_full), .empty(bloc_empty)
  );

  // samples, one block of FFT_SIZE words per ring slot
  block_ram #(.DEPTH(FFT_SIZE * BLOCK_QTY), .word_t(cp_pkg::sample_t)) i_sample_ram (
    .clk_rd, .wr_en, .wr_addr, .wr_data(din_data), .rd_addr, .rd_data
  );

  // one stamp per slot, read follows the oldest block
  block_ram #(.DEPTH(BLOCK_QTY), .word_t(cp_pkg::stamp_t)) i_stamp_ram (
    .clk_rd, .wr_en(stamp_en), .wr_addr(wr_block), .wr_data(wr_stamp),
    .rd_addr(rd_block), .rd_data(dout_stamp)
  );

  cp_reader #(
    .FFT_SIZE(FFT_SIZE), .CP_LEN_LONG(CP_LEN_LONG), .CP_LEN_SHORT(CP_LEN_SHORT),
    .BLOCK_QTY(BLOCK_QTY)
  ) i_cp_reader (
    .clk_rd, .rst_n, .dout_trigger, .long_cp, .dout_repeat, .dout_ready, .dout_enable,
    .empty(bloc_empty), .rd_block, .rd_data, .rd_addr, .rd_release, .dout_sop,
    .dout_eop, .dout_valid, .dmem_valid, .dout_real, .dout_imag, .dout_index
  );

endmodule

//--- dv/cp_tests.svh
/* directed tests for cp_insertion, included inside the testbench module
   every task starts and ends 2 ns after a rising clock edge */
`ifndef CP_TESTS_SVH
`define CP_TESTS_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic cp_pkg::stamp_t make_stamp(input int n);
  cp_pkg::stamp_t s;
  s.frame  = 10'(100 + n);
  s.slot   = 8'(3 * n + 1);
  s.symbol = 4'(n);                          // distinct per packet
  return s;
endfunction

task automatic check_value(input string what, input int got, input int exp);
  check_cnt++;
  assert (got == exp) else begin
    $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    error_cnt++;
  end
endtask

task automatic next_cycles(input int n);
  repeat (n) begin
    @(posedge clk_rd);
    #2;
  end
endtask

// one full packet, kept in the model only when the DUT should store it
task automatic write_packet(input cp_pkg::stamp_t stamp, input bit store);
  for (int i = 0; i < FFT_SIZE; i++) begin
    rng_state = xorshift32(rng_state);
    if (store) begin
      model_q.push_back(rng_state);
    end
    din_valid = 1'b1;
    din_sop   = (i == 0);
    din_eop   = (i == FFT_SIZE - 1);
    din_data  = cp_pkg::sample_t'(rng_state);
    din_stamp = stamp;
    next_cycles(1);
  end
  din_valid = 1'b0;
  din_sop   = 1'b0;
  din_eop   = 1'b0;
  if (store) begin
    stamp_q.push_back(stamp);
  end
  next_cycles(1);
endtask

// head of a packet, a restart, then the rest of its beats without eop
task automatic write_restarted_packet(input int beats);
  for (int i = 0; i < beats; i++) begin
    rng_state = xorshift32(rng_state);
    din_valid = 1'b1;
    din_sop   = (i == 0);
    din_data  = cp_pkg::sample_t'(rng_state);
    din_stamp = make_stamp(60);
    next_cycles(1);
  end
  din_valid   = 1'b0;
  din_sop     = 1'b0;
  din_restart = 1'b1;                        // cut before eop
  next_cycles(1);
  din_restart = 1'b0;
  for (int i = beats; i < FFT_SIZE; i++) begin
    rng_state = xorshift32(rng_state);
    din_valid = 1'b1;                        // tail of the cut packet
    din_data  = cp_pkg::sample_t'(rng_state);
    next_cycles(1);
  end
  din_valid = 1'b0;
  next_cycles(1);
endtask

task automatic run_symbol(input logic use_long, input logic hold_block, input logic ready);
  int start_cnt;
  int wait_cycles;
  start_cnt    = sym_cnt;
  wait_cycles  = 0;
  long_cp      = use_long;
  dout_repeat  = hold_block;
  dout_ready   = ready;
  dout_trigger = 1'b1;                       // one cycle pulse
  next_cycles(1);
  dout_trigger = 1'b0;
  while (sym_cnt == start_cnt && wait_cycles < SYM_CYCLES) begin
    next_cycles(1);
    wait_cycles++;
  end
  assert (sym_cnt != start_cnt) else begin
    $display("no output symbol arrived within %0d cycles of the trigger, at %0t",
             SYM_CYCLES, $time);
    error_cnt++;
  end
  next_cycles(2);                            // release reaches bloc_used
endtask

// prefix is the block tail, then the whole block
task automatic check_symbol(input int cp_len, input bit data_on, input logic [1:0] en);
  int src;
  int exp_re;
  int exp_im;
  check_value("symbol length", mon_re.size(), FFT_SIZE + cp_len);
  if (mon_re.size() != FFT_SIZE + cp_len) begin
    return;
  end
  for (int j = 0; j < FFT_SIZE + cp_len; j++) begin
    src    = (j < cp_len) ? FFT_SIZE - cp_len + j : j - cp_len;
    exp_re = (data_on && en[0]) ? int'(model_q[src][15:0]) : 0;
    exp_im = (data_on && en[1]) ? int'(model_q[src][31:16]) : 0;
    check_value("dout_real", mon_re[j], exp_re);
    check_value("dout_imag", mon_im[j], exp_im);
    check_value("dmem_valid", mon_dm[j], int'(data_on));
  end
  if (data_on) begin
    check_value("dout_stamp", int'(mon_stamp), int'(stamp_q[0]));
  end
endtask

task automatic drop_head();
  for (int i = 0; i < FFT_SIZE; i++) begin
    void'(model_q.pop_front());
  end
  void'(stamp_q.pop_front());
endtask

task automatic check_ring(input int used, input bit full, input bit empty);
  check_value("bloc_used", int'(bloc_used), used);
  check_value("bloc_full", int'(bloc_full), int'(full));
  check_value("bloc_empty", int'(bloc_empty), int'(empty));
endtask

task automatic test_prefix_lengths();
  write_packet(make_stamp(1), 1'b1);
  run_symbol(1'b1, 1'b0, 1'b1);
  check_symbol(CP_LEN_LONG, 1'b1, 2'b11);   // 80 samples
  drop_head();
  write_packet(make_stamp(2), 1'b1);
  run_symbol(1'b0, 1'b0, 1'b1);
  check_symbol(CP_LEN_SHORT, 1'b1, 2'b11);  // 72 samples
  drop_head();
  check_ring(0, 1'b0, 1'b1);
endtask

task automatic test_ring_order();
  for (int n = 0; n < 3; n++) begin
    write_packet(make_stamp(10 + n), 1'b1);
  end
  check_ring(3, 1'b0, 1'b0);
  for (int n = 0; n < 3; n++) begin
    run_symbol(1'b1, 1'b0, 1'b1);
    check_symbol(CP_LEN_LONG, 1'b1, 2'b11);
    drop_head();
    check_ring(2 - n, 1'b0, n == 2);         // steps down to empty
  end
endtask

task automatic test_repeat();
  write_packet(make_stamp(20), 1'b1);
  for (int n = 0; n < 3; n++) begin
    run_symbol(1'b0, n < 2, 1'b1);
    check_symbol(CP_LEN_SHORT, 1'b1, 2'b11);  // same block each time
    check_ring((n < 2) ? 1 : 0, 1'b0, n == 2);
  end
  drop_head();
endtask

task automatic test_empty_not_ready();
  run_symbol(1'b1, 1'b0, 1'b1);
  check_symbol(CP_LEN_LONG, 1'b0, 2'b11);   // framed, no data
  check_ring(0, 1'b0, 1'b1);
  write_packet(make_stamp(30), 1'b1);
  run_symbol(1'b0, 1'b0, 1'b0);
  check_symbol(CP_LEN_SHORT, 1'b0, 2'b11);
  check_ring(1, 1'b0, 1'b0);                 // block kept
  run_symbol(1'b1, 1'b0, 1'b1);
  check_symbol(CP_LEN_LONG, 1'b1, 2'b11);
  drop_head();
endtask

task automatic test_overflow_restart();
  for (int n = 0; n < BLOCK_QTY; n++) begin
    write_packet(make_stamp(40 + n), 1'b1);
  end
  write_packet(make_stamp(44), 1'b0);        // ring full, dropped
  check_value("overflow_cnt", int'(overflow_cnt), 1);
  check_ring(BLOCK_QTY, 1'b1, 1'b0);
  for (int n = 0; n < BLOCK_QTY; n++) begin
    run_symbol(1'b1, 1'b0, 1'b1);
    check_symbol(CP_LEN_LONG, 1'b1, 2'b11);
    drop_head();
  end
  check_ring(0, 1'b0, 1'b1);
  write_restarted_packet(FFT_SIZE / 2);
  check_ring(0, 1'b0, 1'b1);                 // tail beats not committed
  write_packet(make_stamp(50), 1'b1);
  run_symbol(1'b0, 1'b0, 1'b1);
  check_symbol(CP_LEN_SHORT, 1'b1, 2'b11);
  drop_head();
  check_value("overflow_cnt", int'(overflow_cnt), 1);
  check_ring(0, 1'b0, 1'b1);
endtask

task automatic test_output_mask();
  write_packet(make_stamp(70), 1'b1);
  write_packet(make_stamp(71), 1'b1);
  dout_enable = 2'b01;                       // real only
  run_symbol(1'b1, 1'b0, 1'b1);
  check_symbol(CP_LEN_LONG, 1'b1, 2'b01);
  drop_head();
  dout_enable = 2'b10;                       // imag only
  run_symbol(1'b0, 1'b0, 1'b1);
  check_symbol(CP_LEN_SHORT, 1'b1, 2'b10);
  drop_head();
  dout_enable = 2'b11;
  check_ring(0, 1'b0, 1'b1);
endtask

`endif

//--- dv/tb_cp_insertion.sv
/* testbench for cp_insertion at the package default sizes
   directed tests come from cp_tests.svh, sample data from a seeded xorshift */
`timescale 1ns/100ps

module tb_cp_insertion;

  localparam int FFT_SIZE        = cp_pkg::FFT_SIZE_DEF;
  localparam int CP_LEN_LONG     = cp_pkg::CP_LEN_LONG_DEF;
  localparam int CP_LEN_SHORT    = cp_pkg::CP_LEN_SHORT_DEF;
  localparam int BLOCK_QTY       = cp_pkg::BLOCK_QTY_DEF;
  localparam int CLK_PERIOD      = 40;
  localparam int PKT_CYCLES      = FFT_SIZE + 4;                 // one packet write
  localparam int SYM_CYCLES      = FFT_SIZE + CP_LEN_LONG + 16;  // trigger to settled
  localparam int WATCHDOG_CYCLES = 20 * PKT_CYCLES + 20 * SYM_CYCLES + 300;

  logic                                       clk_rd;
  logic                                       rst_n;
  logic                                       din_valid;
  logic                                       din_sop;
  logic                                       din_eop;
  logic                                       din_restart;
  cp_pkg::sample_t                            din_data;
  cp_pkg::stamp_t                             din_stamp;
  logic                                       dout_trigger;
  logic                                       long_cp;
  logic                                       dout_repeat;
  logic                                       dout_ready;
  logic [1:0]                                 dout_enable;
  logic                                       dout_sop;
  logic                                       dout_eop;
  logic                                       dout_valid;
  logic                                       dmem_valid;
  logic [15:0]                                dout_real;
  logic [15:0]                                dout_imag;
  cp_pkg::stamp_t                             dout_stamp;
  logic [$clog2(FFT_SIZE + CP_LEN_LONG)-1:0]  dout_index;
  logic [$clog2(BLOCK_QTY + 1)-1:0]           bloc_used;
  logic                                       bloc_full;
  logic                                       bloc_empty;
  logic [31:0]                                overflow_cnt;

  logic [31:0]    rng_state = 32'd82;        // xorshift state
  logic [31:0]    model_q[$];                // samples of stored packets, oldest first
  cp_pkg::stamp_t stamp_q[$];                // one stamp per stored packet
  int             mon_re[$];                 // last symbol seen at the output
  int             mon_im[$];
  int             mon_dm[$];
  cp_pkg::stamp_t mon_stamp;
  int             sym_cnt   = 0;             // completed output symbols
  int             check_cnt = 0;
  int             error_cnt = 0;

  cp_insertion #(
    .FFT_SIZE(FFT_SIZE), .CP_LEN_LONG(CP_LEN_LONG), .CP_LEN_SHORT(CP_LEN_SHORT),
    .BLOCK_QTY(BLOCK_QTY)
  ) i_cp_insertion (.*);

  `include "cp_tests.svh"

  initial begin
    clk_rd = 1'b0;
    forever #(CLK_PERIOD / 2) clk_rd = ~clk_rd;
  end

  // collect each symbol from sop to eop, index must follow the position
  always @(posedge clk_rd) begin
    if (dout_valid) begin
      if (dout_sop) begin
        mon_re.delete();
        mon_im.delete();
        mon_dm.delete();
        mon_stamp = dout_stamp;              // stamp of the block being sent
      end
      check_value("dout_index", int'(dout_index), mon_re.size());
      mon_re.push_back(int'(dout_real));
      mon_im.push_back(int'(dout_imag));
      mon_dm.push_back(int'(dmem_valid));
      if (dout_eop) begin
        sym_cnt++;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("run stopped by the watchdog, the tests did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rst_n        = 1'b0;
    din_valid    = 1'b0;
    din_sop      = 1'b0;
    din_eop      = 1'b0;
    din_restart  = 1'b0;
    din_data     = '0;
    din_stamp    = '0;
    dout_trigger = 1'b0;
    long_cp      = 1'b0;
    dout_repeat  = 1'b0;
    dout_ready   = 1'b1;
    dout_enable  = 2'b11;
    repeat (10) @(posedge clk_rd);
    #2 rst_n = 1'b1;
    next_cycles(2);
    check_ring(0, 1'b0, 1'b1);               // reset state
    check_value("overflow_cnt", int'(overflow_cnt), 0);
    test_prefix_lengths();
    test_ring_order();
    test_repeat();
    test_empty_not_ready();
    test_overflow_restart();
    test_output_mask();
    $display("%0d checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+dv
verilog/cp_pkg.sv
verilog/block_ram.sv
verilog/block_ring.sv
verilog/block_writer.sv
verilog/cp_reader.sv
verilog/cp_insertion.sv
dv/tb_cp_insertion.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the cp_insertion testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_cp_insertion \
  -Mdir obj_dir \
  -f build.f

./obj_dir/Vtb_cp_insertion | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
